/* Makefile */
# Verilator build and run of the object layer testbench
TOP := obj_layer_tb
LOG := sim.log

.PHONY: all run lint clean

all: run

obj_dir/V$(TOP): filelist.f hw/*.sv tb/*.sv
	verilator --binary --timing --assert -Wno-fatal --top-module $(TOP) -f filelist.f

run: obj_dir/V$(TOP)
	./obj_dir/V$(TOP) | tee $(LOG)
	grep -qx "Regression passed" $(LOG)

lint:
	verilator --lint-only -Wall --timing --top-module $(TOP) -f filelist.f

clean:
	rm -rf obj_dir $(LOG)

/* filelist.f */
hw/obj_pkg.sv
hw/obj_video_timing.sv
hw/obj_row_draw.sv
hw/obj_line_ram.sv
hw/obj_pixel_delay.sv
hw/obj_line_buffer.sv
hw/obj_layer_top.sv
tb/obj_layer_tb.sv

/* hw/obj_layer_top.sv */
// ====================================================================
// obj_layer_top
// sprite layer: video timing, row drawer and double line buffer
// ====================================================================
`timescale 1ns/10ps

module obj_layer_top import obj_pkg::*; #(
    parameter int PXL_DLY = 7
) (
    input  logic                 clk,
    input  logic                 rst,
    input  logic                 flip,
    // sprite row descriptor from the host
    input  logic                 obj_load,
    input  logic [8:0]           obj_x,
    input  logic [PAL_W-1:0]     obj_pal,
    input  logic                 obj_hflip,
    input  logic [8*COL_W-1:0]   obj_row,
    // video out
    output logic [PXL_W-1:0]     obj_pxl,
    output logic                 pxl_cen,
    output logic                 lhbl,
    output logic [8:0]           h_count,
    output logic                 line_sel
);

    logic               cen;
    // drawer to line buffer
    logic [PXL_W-1:0]   new_pxl;
    logic [8:0]         posx;

    obj_video_timing u_timing (
        .clk      (clk),
        .rst      (rst),
        .cen      (cen),
        .pxl_cen  (pxl_cen),
        .lhbl     (lhbl),
        .h_count  (h_count),
        .line_sel (line_sel)
    );

    obj_row_draw u_draw (
        .clk       (clk),
        .rst       (rst),
        .cen       (cen),
        .obj_load  (obj_load),
        .obj_x     (obj_x),
        .obj_pal   (obj_pal),
        .obj_hflip (obj_hflip),
        .obj_row   (obj_row),
        .new_pxl   (new_pxl),
        .posx      (posx)
    );

    // output delay is set here for the whole layer
    obj_line_buffer #(
        .PXL_DLY (PXL_DLY)
    ) u_lbuf (
        .clk      (clk),
        .rst      (rst),
        .cen      (cen),
        .pxl_cen  (pxl_cen),
        .lhbl     (lhbl),
        .flip     (flip),
        .line_sel (line_sel),
        .posx     (posx),
        .new_pxl  (new_pxl),
        .obj_pxl  (obj_pxl)
    );

endmodule

/* hw/obj_line_buffer.sv */
// ====================================================================
// obj_line_buffer
// double-buffered sprite line, draw into one while the other is read
// out and erased behind the read, then aligned to the other layers
// ====================================================================
`timescale 1ns/10ps

module obj_line_buffer import obj_pkg::*; #(
    parameter int PXL_DLY = 7
) (
    input  logic               clk,
    input  logic               rst,
    input  logic               cen,
    input  logic               pxl_cen,
    // screen
    input  logic               lhbl,
    input  logic               flip,
    input  logic               line_sel,
    // pixel from the drawer
    input  logic [8:0]         posx,
    input  logic [PXL_W-1:0]   new_pxl,
    output logic [PXL_W-1:0]   obj_pxl
);

    logic [COL_W-1:0]   new_col;

    // registered write-in
    logic [LINE_AW-1:0] wr_addr;
    logic [PXL_W-1:0]   wr_data;
    logic               wr_pend;

    // readout side
    logic [LINE_AW-1:0] rd_addr;
    logic [3:0]         st;
    logic               erase_we;
    logic [PXL_W-1:0]   rd_pxl;

    logic [PXL_W-1:0]   ram_q [2];

    assign new_col = new_pxl[PXL_W-PAL_W-1:0];

    // write flag, cleared once the pixel has landed
    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            wr_pend <= 1'b0;
        end else if (cen) begin
            // skip see-through colour and columns off the right edge
            wr_pend <= !posx[LINE_AW] && (new_col != TRANSP_COL);
        end
    end

    always_ff @(posedge clk) begin
        if (cen) begin
            // screen flip mirrors the column
            wr_addr <= posx[LINE_AW-1:0] ^ {LINE_AW{flip}};
            wr_data <= new_pxl;
        end
    end

    // readout column, held at 0 through blanking
    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            rd_addr <= '0;
        end else if (pxl_cen) begin
            rd_addr <= lhbl ? rd_addr + 1'b1 : '0;
        end
    end

    // pxl_cen staged over the four clk of a pixel
    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            st <= 4'd0;
        end else begin
            st <= {pxl_cen, st[3:1]};
        end
    end

    // erase on the third clk, RAM q still holds the old word
    assign erase_we = lhbl && st[1];

    // capture on the next pxl_cen, column c leaves while h_count is c+1
    always_ff @(posedge clk) begin
        if (st[0]) begin
            rd_pxl <= ram_q[!line_sel];
        end
    end

    for (genvar i = 0; i < 2; i++) begin : g_line
        logic               rd_side;
        logic [LINE_AW-1:0] addr;
        logic [PXL_W-1:0]   data;
        logic               we;

        // line_sel picks the draw buffer, the other one is shown
        assign rd_side = (line_sel != 1'(i));
        assign addr    = rd_side ? rd_addr : wr_addr;
        assign data    = rd_side ? BLANK_PXL : wr_data;
        assign we      = rd_side ? erase_we : (wr_pend && cen);

        obj_line_ram u_ram (
            .clk  (clk),
            .addr (addr),
            .data (data),
            .we   (we),
            .q    (ram_q[i])
        );
    end

    // line up with the other video layers
    obj_pixel_delay #(
        .STAGES (PXL_DLY)
    ) u_dly (
        .clk     (clk),
        .pxl_cen (pxl_cen),
        .din     (rd_pxl),
        .dout    (obj_pxl)
    );

    // a pixel drawn for one line must have landed before the swap,
    // otherwise it would end up in the buffer of the following line
    a_no_write_at_swap: assert property (
        @(posedge clk) disable iff (rst) $changed(line_sel) |-> !wr_pend
    ) else $error("pending sprite write across a line swap");

endmodule

/* hw/obj_line_ram.sv */
// ====================================================================
// obj_line_ram
// one line of object pixels, synchronous write and registered read
// ====================================================================
`timescale 1ns/10ps

module obj_line_ram import obj_pkg::*; (
    input  logic                 clk,
    input  logic [LINE_AW-1:0]   addr,
    input  logic [PXL_W-1:0]     data,
    input  logic                 we,
    output logic [PXL_W-1:0]     q
);

    // one word per visible column
    logic [PXL_W-1:0] mem [2**LINE_AW];

    always_ff @(posedge clk) begin
        if (we) begin
            mem[addr] <= data;
        end
        // read before write on the same address
        q <= mem[addr];
    end

endmodule

/* hw/obj_pixel_delay.sv */
// ====================================================================
// obj_pixel_delay
// pixel-rate shift register aligning the object layer
// ====================================================================
`timescale 1ns/10ps

module obj_pixel_delay import obj_pkg::*; #(
    parameter int STAGES = 7
) (
    input  logic               clk,
    input  logic               pxl_cen,
    input  logic [PXL_W-1:0]   din,
    output logic [PXL_W-1:0]   dout
);

    logic [PXL_W-1:0] sh [STAGES];

    // moves one stage per pixel, not per clk
    always_ff @(posedge clk) begin
        if (pxl_cen) begin
            sh[0] <= din;
            for (int k = 1; k < STAGES; k++) begin
                sh[k] <= sh[k-1];
            end
        end
    end

    assign dout = sh[STAGES-1];

endmodule

/* hw/obj_pkg.sv */
// ====================================================================
// obj_pkg
// shared pixel, line RAM and line timing constants of the object layer
// ====================================================================

package obj_pkg;

    // pixel word is palette above colour index
    localparam int PXL_W = 6;
    localparam int PAL_W = 2;
    localparam int COL_W = 4;

    // one line RAM covers the visible columns
    localparam int LINE_AW = 8;

    // horizontal line timing, in pixel clocks
    localparam int H_TOTAL  = 320;
    localparam int H_ACTIVE = 256;

    // clk cycles per pixel enable
    localparam int CEN_DIV = 4;

    // colour index that lets the layer below show through
    localparam logic [COL_W-1:0] TRANSP_COL = '1;

    // value left behind by the erase after readout
    localparam logic [PXL_W-1:0] BLANK_PXL = '1;

endpackage

/* hw/obj_row_draw.sv */
// ====================================================================
// obj_row_draw
// turns one sprite row descriptor into eight pixel writes
// ====================================================================
`timescale 1ns/10ps

module obj_row_draw import obj_pkg::*; (
    input  logic                 clk,
    input  logic                 rst,
    input  logic                 cen,
    // sprite row descriptor
    input  logic                 obj_load,
    input  logic [8:0]           obj_x,
    input  logic [PAL_W-1:0]     obj_pal,
    input  logic                 obj_hflip,
    input  logic [8*COL_W-1:0]   obj_row,
    // pixel towards the line buffer
    output logic [PXL_W-1:0]     new_pxl,
    output logic [8:0]           posx
);

    // control
    logic                 busy;
    logic [2:0]           cnt;

    // latched descriptor
    logic [8:0]           x_base;
    logic [PAL_W-1:0]     pal;
    logic                 hflip;
    logic [8*COL_W-1:0]   row;

    logic [2:0]           nib_sel;
    logic [9:0]           col_sum;

    // eight pixels, one per write enable
    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            busy <= 1'b0;
            cnt  <= 3'd0;
        end else if (obj_load) begin
            busy <= 1'b1;
            cnt  <= 3'd0;
        end else if (busy && cen) begin
            cnt <= cnt + 3'd1;
            // last nibble goes out on this cen
            if (cnt == 3'd7) begin
                busy <= 1'b0;
            end
        end
    end

    // descriptor is held for the whole row
    always_ff @(posedge clk) begin
        if (obj_load) begin
            x_base <= obj_x;
            pal    <= obj_pal;
            hflip  <= obj_hflip;
            row    <= obj_row;
        end
    end

    // hflip walks the nibbles from the high end, 7-cnt
    assign nib_sel = cnt ^ {3{hflip}};

    // one spare bit so a row running off 511 is not wrapped to column 0
    assign col_sum = {1'b0, x_base} + {7'd0, cnt};

    always_comb begin
        if (busy) begin
            // transparent nibbles pass through, the buffer drops them
            new_pxl = {pal, row[nib_sel*COL_W +: COL_W]};
        end else begin
            new_pxl = BLANK_PXL;
        end
    end

    // past 511 park the column off screen
    assign posx = col_sum[9] ? 9'h1FF : col_sum[8:0];

    // host spacing rule, one row must finish before the next strobe
    a_load_idle: assert property (
        @(posedge clk) disable iff (rst) obj_load |-> !busy
    ) else $error("obj_load while drawer busy");

endmodule

/* hw/obj_video_timing.sv */
// ====================================================================
// obj_video_timing
// clock enables, horizontal counter, blanking and line parity
// ====================================================================
`timescale 1ns/10ps

module obj_video_timing import obj_pkg::*; (
    input  logic       clk,
    input  logic       rst,
    output logic       cen,
    output logic       pxl_cen,
    output logic       lhbl,
    output logic [8:0] h_count,
    output logic       line_sel
);

    // free running divider, CEN_DIV clk per pixel
    logic [1:0] div;
    logic [8:0] h_next;

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            div     <= 2'd0;
            cen     <= 1'b0;
            pxl_cen <= 1'b0;
        end else begin
            div     <= div + 2'd1;
            // write enable at twice the pixel rate
            cen     <= div[0];
            // pixel enable on the last phase, always with cen
            pxl_cen <= (div == 2'(CEN_DIV - 1));
        end
    end

    // next horizontal position, wraps at end of line
    assign h_next = (h_count == 9'(H_TOTAL - 1)) ? 9'd0 : h_count + 9'd1;

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            h_count  <= 9'd0;
            lhbl     <= 1'b0;
            line_sel <= 1'b0;
        end else if (pxl_cen) begin
            h_count <= h_next;
            // high for the visible part of the line
            lhbl    <= (h_next < 9'(H_ACTIVE));
            // new line, swap draw and readout buffers
            if (h_next == 9'd0) begin
                line_sel <= ~line_sel;
            end
        end
    end

    // both enables come from one divider, pxl_cen is a subset of cen
    a_pxl_cen_in_cen: assert property (
        @(posedge clk) disable iff (rst) pxl_cen |-> cen
    ) else $error("pxl_cen high without cen");

endmodule

/* tb/obj_layer_tb.sv */
// ====================================================================
// obj_layer_tb
// random sprite rows checked against a per-line model of the layer
// ====================================================================
`timescale 1ns/10ps

module obj_layer_tb import obj_pkg::*; ();

    localparam int PXL_DLY      = 7;
    // two full lines of clk
    localparam int SWAP_TIMEOUT = 2 * H_TOTAL * CEN_DIV;

    // sprite generators
    localparam int MODE_PLAIN   = 0;
    localparam int MODE_OVERLAP = 1;
    localparam int MODE_HFLIP   = 2;
    localparam int MODE_CLIP    = 3;
    localparam int MODE_MIXED   = 4;

    logic                 clk;
    logic                 rst;
    logic                 flip;
    logic                 obj_load;
    logic [8:0]           obj_x;
    logic [PAL_W-1:0]     obj_pal;
    logic                 obj_hflip;
    logic [8*COL_W-1:0]   obj_row;
    logic [PXL_W-1:0]     obj_pxl;
    logic                 pxl_cen;
    logic                 lhbl;
    logic [8:0]           h_count;
    logic                 line_sel;

    integer               seed;
    int                   n_err;
    int                   n_checks;
    logic                 check_en;
    logic                 primed;
    logic                 flip_now;
    logic [31:0]          r_flip;

    // line being drawn and line being shown
    logic [PXL_W-1:0]     drawn [H_ACTIVE];
    logic [PXL_W-1:0]     shown [H_ACTIVE];

    obj_layer_top #(
        .PXL_DLY (PXL_DLY)
    ) UUT (
        .clk       (clk),
        .rst       (rst),
        .flip      (flip),
        .obj_load  (obj_load),
        .obj_x     (obj_x),
        .obj_pal   (obj_pal),
        .obj_hflip (obj_hflip),
        .obj_row   (obj_row),
        .obj_pxl   (obj_pxl),
        .pxl_cen   (pxl_cen),
        .lhbl      (lhbl),
        .h_count   (h_count),
        .line_sel  (line_sel)
    );

    initial begin
        clk = 1'b0;
        forever #4 clk = ~clk;
    end

    task automatic check_value(input string name, input int col,
                               input logic [8:0] got,
                               input logic [8:0] exp);
        n_checks++;
        if (got !== exp) begin
            n_err++;
            $display("Mismatch %s col %0d: got %h, expected %h", name, col, got, exp);
        end
    endtask

    task automatic finish_run();
        if (n_checks == 0) begin
            n_err++;
            $display("no pixel of the object layer was compared");
        end
        $display("checks %0d, errors %0d", n_checks, n_err);
        if (n_err == 0) begin
            $display("Regression passed");
        end else begin
            $display("Regression failed");
        end
        $finish;
    endtask

    task automatic wait_line_swap();
        logic prev;
        int   n;
        prev = line_sel;
        n    = 0;
        while (line_sel == prev && n < SWAP_TIMEOUT) begin
            @(posedge clk);
            n++;
        end
        if (line_sel == prev) begin
            n_err++;
            $display("line_sel did not toggle within %0d clock cycles", SWAP_TIMEOUT);
            finish_run();
        end
    endtask

    // new line: last drawn line goes on screen, fresh line starts blank
    task automatic begin_line(input logic line_flip);
        wait_line_swap();
        shown = drawn;
        foreach (drawn[i]) begin
            drawn[i] = BLANK_PXL;
        end
        check_en = primed;
        primed   = 1'b1;
        flip     <= line_flip;
        flip_now = line_flip;
    endtask

    // later loads overwrite, see-through nibbles keep what is below
    function automatic void paint(input logic [8:0] x, input logic [PAL_W-1:0] pal,
                                  input logic hf, input logic [8*COL_W-1:0] row);
        int               col;
        logic [COL_W-1:0] nib;
        logic [7:0]       addr;
        for (int i = 0; i < 8; i++) begin
            col = int'(x) + i;
            nib = hf ? row[(7-i)*COL_W +: COL_W] : row[i*COL_W +: COL_W];
            if (col < H_ACTIVE && nib != TRANSP_COL) begin
                addr = flip_now ? 8'(H_ACTIVE - 1 - col) : 8'(col);
                drawn[addr] = {pal, nib};
            end
        end
    endfunction

    task automatic random_sprite(input int mode, output logic [8:0] x,
                                 output logic [PAL_W-1:0] pal, output logic hf,
                                 output logic [8*COL_W-1:0] row);
        logic [31:0]      r;
        logic [COL_W-1:0] nib;
        r   = $random(seed);
        pal = r[13:12];
        hf  = 1'b0;
        case (mode)
            MODE_OVERLAP: x = 9'd96 + {4'd0, r[4:0]};
            // right edge, a few past 503 so the row runs off 511
            MODE_CLIP:    x = r[11] ? {6'h3F, r[2:0]} : 9'd244 + {1'b0, r[7:0]};
            MODE_MIXED:   x = r[8:0];
            default:      x = {1'b0, r[7:0]};
        endcase
        if ((mode == MODE_PLAIN || mode == MODE_HFLIP) && x > 9'd248) begin
            x = x - 9'd8;
        end
        if (mode == MODE_HFLIP) begin
            hf = 1'b1;
        end else if (mode == MODE_CLIP || mode == MODE_MIXED) begin
            hf = r[10];
        end
        for (int i = 0; i < 8; i++) begin
            r   = $random(seed);
            nib = r[3:0];
            if (mode == MODE_PLAIN) begin
                if (nib == TRANSP_COL) begin
                    nib = r[7:4] & 4'h7;
                end
            end else if (r[9:8] == 2'b00) begin
                // about one nibble in four see-through
                nib = TRANSP_COL;
            end
            row[i*COL_W +: COL_W] = nib;
        end
    endtask

    // one strobe, then idle past the drawer's eight write enables
    task automatic load_sprite(input logic [8:0] x, input logic [PAL_W-1:0] pal,
                               input logic hf, input logic [8*COL_W-1:0] row);
        @(posedge clk);
        obj_load  <= 1'b1;
        obj_x     <= x;
        obj_pal   <= pal;
        obj_hflip <= hf;
        obj_row   <= row;
        paint(x, pal, hf, row);
        @(posedge clk);
        obj_load <= 1'b0;
        repeat (18) @(posedge clk);
    endtask

    task automatic draw_line(input int mode, input int n_obj, input logic line_flip);
        logic [8:0]         x;
        logic [PAL_W-1:0]   pal;
        logic               hf;
        logic [8*COL_W-1:0] row;
        begin_line(line_flip);
        for (int k = 0; k < n_obj; k++) begin
            random_sprite(mode, x, pal, hf, row);
            load_sprite(x, pal, hf, row);
        end
    endtask

    // column c is on obj_pxl while h_count is c+PXL_DLY+1
    initial begin : capture
        int         idx;
        int         gap;
        logic [8:0] h_prev;
        logic       sel_prev;
        gap      = 0;
        h_prev   = '0;
        sel_prev = 1'b0;
        forever begin
            @(negedge clk);
            gap++;
            if (pxl_cen) begin
                if (check_en) begin
                    // one pixel every CEN_DIV clk, counter wraps at end of line
                    check_value("pxl_cen", int'(h_count), 9'(gap), 9'(CEN_DIV));
                    check_value("h_count", int'(h_count), h_count,
                                9'((int'(h_prev) + 1) % H_TOTAL));
                    check_value("lhbl", int'(h_count), 9'(lhbl),
                                9'(int'(h_count) < H_ACTIVE));
                    // parity flips only where a new line begins
                    check_value("line_sel", int'(h_count), 9'(line_sel),
                                9'(sel_prev ^ (h_count == 9'd0)));
                    idx = int'(h_count) - PXL_DLY - 1;
                    if (idx >= 0 && idx < H_ACTIVE) begin
                        check_value("obj_pxl", idx, 9'(obj_pxl), 9'(shown[idx]));
                    end
                end
                h_prev   = h_count;
                sel_prev = line_sel;
                gap      = 0;
            end
        end
    end

    initial begin
        seed      = 32'hf064_b689;
        n_err     = 0;
        n_checks  = 0;
        check_en  = 1'b0;
        primed    = 1'b0;
        flip_now  = 1'b0;
        rst       = 1'b1;
        flip      = 1'b0;
        obj_load  = 1'b0;
        obj_x     = 9'd0;
        obj_pal   = '0;
        obj_hflip = 1'b0;
        obj_row   = '0;
        foreach (drawn[i]) begin
            drawn[i] = BLANK_PXL;
        end
        repeat (8) @(posedge clk);
        rst <= 1'b0;

        // RAM starts unknown, first lines are only flushed through
        wait_line_swap();

        repeat (3) draw_line(MODE_PLAIN, 1, 1'b0);
        repeat (3) draw_line(MODE_OVERLAP, 6, 1'b0);
        repeat (3) draw_line(MODE_HFLIP, 4, 1'b0);
        repeat (3) draw_line(MODE_MIXED, 5, 1'b1);
        repeat (2) draw_line(MODE_CLIP, 4, 1'b0);
        draw_line(MODE_CLIP, 4, 1'b1);
        repeat (4) begin
            r_flip = $random(seed);
            draw_line(MODE_MIXED, 8, r_flip[0]);
        end

        // busy line then empty lines, both buffers must come back blank
        draw_line(MODE_MIXED, 10, 1'b0);
        repeat (3) draw_line(MODE_MIXED, 0, 1'b0);
        wait_line_swap();
        finish_run();
    end

endmodule
